/* rtl/load_pkg.sv */
/*
 * Download bus types
 * Host download stream, ROM write port and the cheat code word
 */

package load_pkg;

	// Default byte address width of the download bus
	parameter int unsigned DL_ADDR_W = 25;

	// What the current download carries
	typedef enum logic {
		TARGET_CART,
		TARGET_CHEAT
	} dl_target_t;

	// One cycle of the host download bus
	typedef struct packed {
		logic                 download;
		dl_target_t           target;
		logic                 wr;
		logic [DL_ADDR_W-1:0] addr;
		logic [15:0]          data;
	} dl_bus_t;

	// ROM write port, data already byte-swapped
	typedef struct packed {
		logic [DL_ADDR_W-1:0] addr;
		logic [15:0]          data;
	} rom_wr_t;

	// Cheat code, each field big endian as the loader sends it
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

/* rtl/cart_pkg.sv */
/*
 * Cartridge content definitions
 * Header offsets, region codes, region priority orders and game quirks
 */

package cart_pkg;

	//////////////////////////////////////////////////////////////////////
	// Header byte offsets
	//////////////////////////////////////////////////////////////////////

	// Both bytes are region letters
	parameter int unsigned HDR_REGION_ADDR  = 'h1F0;
	// Low byte only is a region letter
	parameter int unsigned HDR_REGION2_ADDR = 'h1F2;
	// Header complete
	parameter int unsigned HDR_END_ADDR     = 'h200;

	// Product ID words, match fires on the word after the last one
	parameter int unsigned ID_FIRST_ADDR    = 'h182;
	parameter int unsigned ID_DONE_ADDR     = 'h18C;

	//////////////////////////////////////////////////////////////////////
	// Regions and quirks
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// Search order used when several letters are present
	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_t;

	// Eight ASCII characters, first one in the top byte
	typedef logic [63:0] product_id_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic fifo;
		logic svp;
	} cart_quirks_t;

endpackage

/* rtl/rom_writer.sv */
/*
 * ROM writer
 * Forwards cartridge words to ROM memory over a four-phase req/ack
 * handshake, holds the host off meanwhile and records the ROM size
 */

module rom_writer import load_pkg::*; #(
	parameter int unsigned ADDR_W = DL_ADDR_W
) (
	input  logic              clk_sys,
	input  logic              rst,
	input  dl_bus_t           dl,
	input  logic              rom_ack,
	output logic              rom_req,
	output rom_wr_t           rom_wr,
	output logic              dl_wait,
	output logic [ADDR_W-1:0] rom_size
);

	logic cart_dl;
	logic cart_dl_q;
	logic wr_pend;

	assign cart_dl = dl.download && (dl.target == TARGET_CART);

	// Word and address held stable for the whole handshake
	always_ff @(posedge clk_sys) begin
		if (cart_dl && dl.wr) begin
			rom_wr.addr <= dl.addr;
			rom_wr.data <= {dl.data[7:0], dl.data[15:8]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cart_dl_q <= 1'b0;
			wr_pend   <= 1'b0;
			rom_req   <= 1'b0;
			dl_wait   <= 1'b0;
			rom_size  <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			wr_pend   <= cart_dl && dl.wr;

			// Phase 1 starts, phase 3 once memory acks
			if (wr_pend)
				rom_req <= 1'b1;
			else if (rom_req && rom_ack)
				rom_req <= 1'b0;

			// Release the host only after ack has dropped again
			if (wr_pend)
				dl_wait <= 1'b1;
			else if (dl_wait && !rom_req && !rom_ack)
				dl_wait <= 1'b0;

			// End of cartridge download
			if (cart_dl_q && !cart_dl)
				rom_size <= ADDR_W'(dl.addr);
		end
	end

endmodule

/* rtl/header_region.sv */
/*
 * Header region detection
 * Collects the region letters of the cartridge header and picks a region
 * from them in the selected priority order
 */

module header_region import load_pkg::*, cart_pkg::*; (
	input  logic         clk_sys,
	input  logic         rst,
	input  dl_bus_t      dl,
	input  region_prio_t prio,
	output region_t      region,
	output logic         region_hold
);

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} letters_t;

	letters_t letters;
	logic     cart_dl;
	logic     cart_dl_q;
	logic     hdr_wr;

	// One header character to letter flags
	function automatic letters_t classify(input logic [7:0] ch);
		if (ch == "J")
			return '{j: 1'b1, u: 1'b0, e: 1'b0};
		else if (ch == "U")
			return '{j: 1'b0, u: 1'b1, e: 1'b0};
		else if (ch >= "0" && ch <= "Z")
			return '{j: 1'b0, u: 1'b0, e: 1'b1};
		else
			return '0;
	endfunction

	// First flagged region in the order, else the order's first region
	function automatic region_t pick_region(input region_prio_t p, input letters_t f);
		case (p)
			PRIO_US_EU_JP:
				if (f.u) return REGION_US;
				else if (f.e) return REGION_EU;
				else if (f.j) return REGION_JP;
				else return REGION_US;
			PRIO_EU_US_JP:
				if (f.e) return REGION_EU;
				else if (f.u) return REGION_US;
				else if (f.j) return REGION_JP;
				else return REGION_EU;
			PRIO_US_JP_EU:
				if (f.u) return REGION_US;
				else if (f.j) return REGION_JP;
				else if (f.e) return REGION_EU;
				else return REGION_US;
			default:
				if (f.j) return REGION_JP;
				else if (f.u) return REGION_US;
				else if (f.e) return REGION_EU;
				else return REGION_JP;
		endcase
	endfunction

	assign cart_dl = dl.download && (dl.target == TARGET_CART);
	assign hdr_wr  = cart_dl && dl.wr;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cart_dl_q   <= 1'b0;
			letters     <= '0;
			region      <= REGION_JP;
			region_hold <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;

			if (cart_dl && !cart_dl_q)
				letters <= '0;
			if (cart_dl_q && !cart_dl)
				region_hold <= 1'b0;

			if (hdr_wr && dl.addr == DL_ADDR_W'(HDR_REGION_ADDR))
				letters <= letters | classify(dl.data[7:0]) | classify(dl.data[15:8]);
			if (hdr_wr && dl.addr == DL_ADDR_W'(HDR_REGION2_ADDR))
				letters <= letters | classify(dl.data[7:0]);

			if (hdr_wr && dl.addr == DL_ADDR_W'(HDR_END_ADDR)) begin
				region      <= pick_region(prio, letters);
				region_hold <= 1'b1;
			end
		end
	end

endmodule

/* rtl/quirk_detect.sv */
/*
 * Quirk detection
 * Builds the product ID from the header and flags games that need
 * special handling by the console core
 */

module quirk_detect import load_pkg::*, cart_pkg::*; (
	input  logic         clk_sys,
	input  logic         rst,
	input  dl_bus_t      dl,
	output cart_quirks_t quirks
);

	product_id_t cart_id;
	logic        cart_dl;
	logic        cart_dl_q;
	logic        id_wr;

	function automatic cart_quirks_t match_id(input product_id_t id);
		cart_quirks_t q;
		q = '0;
		case (id)
			"T-081276", "T-81406 ": q.sram   = 1'b1;
			"MK-1215 ", "G-4060  ": q.eeprom = 1'b1;
			"T-89016 ":             q.fifo   = 1'b1;
			"MK-1229 ", "G-7001  ": q.svp    = 1'b1;
			default:                q        = '0;
		endcase
		return q;
	endfunction

	assign cart_dl = dl.download && (dl.target == TARGET_CART);
	assign id_wr   = cart_dl && dl.wr;

	// ID text starts on an odd byte, so words arrive straddling characters
	always_ff @(posedge clk_sys) begin
		if (id_wr) begin
			case (dl.addr)
				DL_ADDR_W'(ID_FIRST_ADDR):     cart_id[63:56] <= dl.data[15:8];
				DL_ADDR_W'(ID_FIRST_ADDR + 2): cart_id[55:40] <= {dl.data[7:0], dl.data[15:8]};
				DL_ADDR_W'(ID_FIRST_ADDR + 4): cart_id[39:24] <= {dl.data[7:0], dl.data[15:8]};
				DL_ADDR_W'(ID_FIRST_ADDR + 6): cart_id[23:8]  <= {dl.data[7:0], dl.data[15:8]};
				DL_ADDR_W'(ID_FIRST_ADDR + 8): cart_id[7:0]   <= dl.data[7:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cart_dl_q <= 1'b0;
			quirks    <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl && !cart_dl_q)
				quirks <= '0;
			else if (id_wr && dl.addr == DL_ADDR_W'(ID_DONE_ADDR))
				quirks <= match_id(cart_id);
		end
	end

endmodule

/* rtl/cheat_loader.sv */
/*
 * Cheat code loader
 * Assembles 16-bit cheat download words into one code and clocks it in
 */

module cheat_loader import load_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,
	input  dl_bus_t     dl,
	output cheat_code_t cheat,
	output logic        cheat_strobe,
	output logic        cheat_reset
);

	logic code_wr;

	assign code_wr = dl.download && (dl.target == TARGET_CHEAT) && dl.wr;

	// Low word of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				4'd0:  cheat.flags[15:0]    <= dl.data;
				4'd2:  cheat.flags[31:16]   <= dl.data;
				4'd4:  cheat.addr[15:0]     <= dl.data;
				4'd6:  cheat.addr[31:16]    <= dl.data;
				4'd8:  cheat.compare[15:0]  <= dl.data;
				4'd10: cheat.compare[31:16] <= dl.data;
				4'd12: cheat.replace[15:0]  <= dl.data;
				4'd14: cheat.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cheat_strobe <= 1'b0;
			cheat_reset  <= 1'b0;
		end else begin
			// Code complete with the replace top word
			cheat_strobe <= code_wr && (dl.addr[3:0] == 4'd14);
			// First word of the cheat file clears the old list
			cheat_reset  <= code_wr && (dl.addr == '0);
		end
	end

endmodule

/* rtl/cart_loader.sv */
/*
 * Cartridge loader
 * Download front end of the console core: ROM writing, header region
 * detection, quirk detection and cheat code assembly
 */

module cart_loader import load_pkg::*, cart_pkg::*; #(
	parameter int unsigned ADDR_W = DL_ADDR_W
) (
	input  logic              clk_sys,
	input  logic              rst,
	input  dl_bus_t           dl,
	output logic              dl_wait,
	output logic              rom_req,
	output rom_wr_t           rom_wr,
	input  logic              rom_ack,
	output logic [ADDR_W-1:0] rom_size,
	input  region_prio_t      prio,
	output region_t           region,
	output logic              region_hold,
	output cart_quirks_t      quirks,
	output cheat_code_t       cheat,
	output logic              cheat_strobe,
	output logic              cheat_reset
);

	// Only the ROM writer ever stalls the host
	rom_writer #(
		.ADDR_W(ADDR_W)
	) u_rom_writer (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.dl       (dl),
		.rom_ack  (rom_ack),
		.rom_req  (rom_req),
		.rom_wr   (rom_wr),
		.dl_wait  (dl_wait),
		.rom_size (rom_size)
	);

	header_region u_header_region (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.dl          (dl),
		.prio        (prio),
		.region      (region),
		.region_hold (region_hold)
	);

	quirk_detect u_quirk_detect (
		.clk_sys (clk_sys),
		.rst     (rst),
		.dl      (dl),
		.quirks  (quirks)
	);

	cheat_loader u_cheat_loader (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.dl           (dl),
		.cheat        (cheat),
		.cheat_strobe (cheat_strobe),
		.cheat_reset  (cheat_reset)
	);

endmodule

/* test/tb_cart_loader.sv */
/*
 * Testbench for the cartridge loader
 * Host and ROM memory models, region, quirk and cheat scenarios,
 * protocol monitors on the ROM handshake and the download bus
 */

module tb_cart_loader import load_pkg::*, cart_pkg::*; ();

	// About 100 words, at most 12 cycles each, three times over plus margin
	localparam int TEST_WORDS     = 12 + 8 * 10 + 8;
	localparam int TIMEOUT_CYCLES = 3 * TEST_WORDS * 12 + 400;

	logic         clk_sys;
	logic         rst;
	dl_bus_t      dl;
	logic         dl_wait;
	logic         rom_req;
	rom_wr_t      rom_wr;
	logic         rom_ack;
	logic [24:0]  rom_size;
	region_prio_t prio;
	region_t      region;
	logic         region_hold;
	cart_quirks_t quirks;
	cheat_code_t  cheat;
	logic         cheat_strobe;
	logic         cheat_reset;

	int          errors;
	int          checks;
	int          cycles;
	int          strobes;
	int          resets;
	logic [31:0] lfsr;
	logic [31:0] ack_delay;
	logic        req_q;
	logic        ack_q;
	rom_wr_t     rom_expect[$];
	rom_wr_t     rom_seen;

	cart_loader uut (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.dl           (dl),
		.dl_wait      (dl_wait),
		.rom_req      (rom_req),
		.rom_wr       (rom_wr),
		.rom_ack      (rom_ack),
		.rom_size     (rom_size),
		.prio         (prio),
		.region       (region),
		.region_hold  (region_hold),
		.quirks       (quirks),
		.cheat        (cheat),
		.cheat_strobe (cheat_strobe),
		.cheat_reset  (cheat_reset)
	);

	always #5 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] t=%0t %s: got 'h%0h, expected 'h%0h", $time, name, got, exp);
		end
	endtask

	// Header byte: ID text at 'h183..'h18A, else a pattern of the address
	function automatic logic [7:0] byte_at(input logic [63:0] id, input int a);
		if (a >= 'h183 && a <= 'h18A)
			return id[63 - 8 * (a - 'h183) -: 8];
		return 8'(a ^ (a >> 8));
	endfunction

	// First region of the order whose letter is present, else the first one
	function automatic region_t expect_region(input region_prio_t p, input logic [23:0] txt);
		logic    j;
		logic    u;
		logic    e;
		logic    hit;
		logic [7:0] ch;
		region_t order [0:2];
		region_t pick;
		int      k;
		j = 1'b0;
		u = 1'b0;
		e = 1'b0;
		for (k = 0; k < 3; k++) begin
			ch = txt[23 - 8 * k -: 8];
			if (ch == "J")
				j = 1'b1;
			else if (ch == "U")
				u = 1'b1;
			else if (ch >= "0" && ch <= "Z")
				e = 1'b1;
		end
		case (p)
			PRIO_US_EU_JP: order = '{REGION_US, REGION_EU, REGION_JP};
			PRIO_EU_US_JP: order = '{REGION_EU, REGION_US, REGION_JP};
			PRIO_US_JP_EU: order = '{REGION_US, REGION_JP, REGION_EU};
			default:       order = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		pick = order[0];
		for (k = 2; k >= 0; k--) begin
			hit = (order[k] == REGION_JP && j) || (order[k] == REGION_US && u) ||
				(order[k] == REGION_EU && e);
			if (hit)
				pick = order[k];
		end
		return pick;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Host model, every task starts and ends right after a falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic begin_download(input dl_target_t t);
		dl.target   = t;
		dl.download = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic end_download();
		while (dl_wait)
			@(negedge clk_sys);
		dl.download = 1'b0;
		@(negedge clk_sys);
	endtask

	// One wr strobe, then one idle cycle before the next one may come
	task automatic write_word(input int a, input logic [15:0] d);
		while (dl_wait)
			@(negedge clk_sys);
		dl.wr   = 1'b1;
		dl.addr = 25'(a);
		dl.data = d;
		if (dl.target == TARGET_CART)
			rom_expect.push_back('{addr: 25'(a), data: {d[7:0], d[15:8]}});
		@(negedge clk_sys);
		dl.wr = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic load_cart(input logic [63:0] id, input logic [23:0] txt,
			input region_prio_t p, input cart_quirks_t exp_q);
		int a;
		prio = p;
		begin_download(TARGET_CART);
		check_value("quirks", quirks, '0);
		for (a = 'h180; a <= 'h18C; a += 2)
			write_word(a, {byte_at(id, a + 1), byte_at(id, a)});
		check_value("quirks", quirks, exp_q);
		write_word('h1F0, {txt[15:8], txt[23:16]});
		// High byte of 'h1F2 is no region letter
		write_word('h1F2, {"J", txt[7:0]});
		write_word('h200, 16'h4E41);
		while (dl_wait)
			@(negedge clk_sys);
		check_value("region", region, expect_region(p, txt));
		check_value("region_hold", region_hold, 1'b1);
		end_download();
		check_value("region_hold", region_hold, 1'b0);
		check_value("rom_size", rom_size, 'h200);
	endtask

	//////////////////////////////////////////////////////////////////////
	// ROM memory model and protocol monitors
	//////////////////////////////////////////////////////////////////////

	always begin
		@(negedge clk_sys);
		if (!rst && rom_req && !rom_ack) begin
			draw_bits(2, ack_delay);
			repeat (ack_delay)
				@(negedge clk_sys);
			if (rom_expect.size() == 0) begin
				errors++;
				$display("t=%0t: ROM request without a pending cartridge write", $time);
			end else begin
				rom_seen = rom_expect.pop_front();
				check_value("rom_wr.addr", rom_wr.addr, rom_seen.addr);
				check_value("rom_wr.data", rom_wr.data, rom_seen.data);
			end
			rom_ack = 1'b1;
		end else if (!rom_req && rom_ack) begin
			rom_ack = 1'b0;
		end
	end

	always @(posedge clk_sys) begin
		if (!rst) begin
			assert (!(rom_req && !req_q && ack_q)) else begin
				errors++;
				$display("t=%0t: rom_req rose while rom_ack was still high", $time);
			end
			// Host follows dl_wait, so a late or early dl_wait shows up here
			assert (!(dl.wr && dl.target == TARGET_CART && (rom_req || rom_ack))) else begin
				errors++;
				$display("t=%0t: host wrote while a ROM write was in flight", $time);
			end
			assert (!(rom_req && dl.download && dl.target == TARGET_CHEAT)) else begin
				errors++;
				$display("t=%0t: ROM request during a cheat download", $time);
			end
			if (cheat_strobe)
				strobes++;
			if (cheat_reset)
				resets++;
		end
		req_q <= rom_req;
		ack_q <= rom_ack;
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Errors found");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		int           t;
		int           p;
		int           i;
		logic [31:0]  r;
		logic [15:0]  words [0:7];
		logic [15:0]  rom_words [0:11];
		cart_quirks_t exp_q;
		logic [63:0]  id;
		logic [23:0]  txt;

		clk_sys = 1'b0;
		rst     = 1'b1;
		dl      = '0;
		prio    = PRIO_US_EU_JP;
		rom_ack = 1'b0;
		lfsr    = 32'hf7ad;
		errors  = 0;
		checks  = 0;
		cycles  = 0;
		strobes = 0;
		resets  = 0;
		repeat (5)
			@(negedge clk_sys);
		rst = 1'b0;

		// Reset state
		check_value("rom_req", rom_req, 1'b0);
		check_value("dl_wait", dl_wait, 1'b0);
		check_value("region_hold", region_hold, 1'b0);
		check_value("cheat_strobe", cheat_strobe, 1'b0);
		check_value("cheat_reset", cheat_reset, 1'b0);
		check_value("quirks", quirks, '0);

		// Plain ROM download of 12 words, data drawn while memory is idle
		for (i = 0; i < 12; i++) begin
			draw_bits(16, r);
			rom_words[i] = r[15:0];
		end
		begin_download(TARGET_CART);
		for (i = 0; i < 12; i++)
			write_word(2 * i, rom_words[i]);
		end_download();
		check_value("rom_size", rom_size, 22);

		// Cheat code, flags low word first
		begin_download(TARGET_CHEAT);
		for (i = 0; i < 8; i++) begin
			draw_bits(16, r);
			words[i] = r[15:0];
			write_word(2 * i, words[i]);
		end
		end_download();
		check_value("cheat.flags", cheat.flags, {words[1], words[0]});
		check_value("cheat.addr", cheat.addr, {words[3], words[2]});
		check_value("cheat.compare", cheat.compare, {words[5], words[4]});
		check_value("cheat.replace", cheat.replace, {words[7], words[6]});
		check_value("cheat_strobe pulses", strobes, 1);
		check_value("cheat_reset pulses", resets, 1);

		// Region under every order, SVP title and unknown title alternating
		for (t = 0; t < 2; t++) begin
			for (p = 0; p < 4; p++) begin
				txt   = (t == 0) ? "JU " : "E  ";
				exp_q = '0;
				if (p % 2 == 0) begin
					id        = "MK-1229 ";
					exp_q.svp = 1'b1;
				end else begin
					id = "T-12345 ";
				end
				load_cart(id, txt, region_prio_t'(p), exp_q);
			end
		end

		check_value("pending ROM writes", rom_expect.size(), 0);
		repeat (2)
			@(negedge clk_sys);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* sim.f */
rtl/load_pkg.sv
rtl/cart_pkg.sv
rtl/rom_writer.sv
rtl/header_region.sv
rtl/quirk_detect.sv
rtl/cheat_loader.sv
rtl/cart_loader.sv
test/tb_cart_loader.sv

/* Bender.yml */
package:
  name: cart_loader

sources:
  - rtl/load_pkg.sv
  - rtl/cart_pkg.sv
  - rtl/rom_writer.sv
  - rtl/header_region.sv
  - rtl/quirk_detect.sv
  - rtl/cheat_loader.sv
  - rtl/cart_loader.sv
  - target: test
    files:
      - test/tb_cart_loader.sv
